/* design/fpu_mul_settings.svh */
`ifndef FPU_MUL_SETTINGS_SVH
`define FPU_MUL_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// single precision format
//////////////////////////////////////////////////////////////////////

// stored fraction bits, hidden one not counted
`define FPU_FRAC_W 23
// biased exponent field
`define FPU_EXP_W 8
`define FPU_EXP_BIAS 127 // single precision bias

//////////////////////////////////////////////////////////////////////
// iterative multiplier
//////////////////////////////////////////////////////////////////////

// radix-4 steps, two multiplier bits retired per step
`define FPU_MUL_STEPS 12

`endif

/* design/fpu_mul_fmt_pkg.sv */
`include "fpu_mul_settings.svh"

// number format and result encodings shared by both datapaths
package fpu_mul_fmt_pkg;

	// ieee-754 word, msb first
	typedef struct packed {
		logic                   sign;
		logic [`FPU_EXP_W-1:0]  exp;  // biased
		logic [`FPU_FRAC_W-1:0] frac; // hidden one not stored
	} fp_word_t;

	// operand class, decided at capture
	typedef enum logic [1:0] {
		CLS_ZERO, // zero or denormal, both flushed
		CLS_NORM,
		CLS_INF,
		CLS_NAN
	} op_class_e;

	// what the pack stage puts on the result
	typedef enum logic [1:0] {
		RES_NUM,  // rounded product
		RES_ZERO, // signed zero
		RES_INF,  // signed infinity
		RES_QNAN  // canonical quiet nan 7fc00000
	} res_sel_e;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} mul_flags_t;

endpackage

/* design/fpu_mul_ctl_pkg.sv */
package fpu_mul_ctl_pkg; // sequencing types

	typedef enum logic [2:0] {
		ST_IDLE,  // waiting for start
		ST_MUL,   // shift-add steps
		ST_NORM,  // one-position post normalize
		ST_ROUND, // nearest even
		ST_PACK   // result and flags registered
	} mul_state_e;

	// one strobe per phase and at most one high in any cycle
	typedef struct packed {
		logic load;     // capture operands and classify
		logic mul_step; // retire two multiplier bits
		logic norm;
		logic round;
		logic pack;
	} step_ctl_t;

endpackage

/* design/fpu_mul_ctl.sv */
`timescale 1ns/10ps

module fpu_mul_ctl
	import fpu_mul_ctl_pkg::*;
(
	input  logic      i_rclk,
	input  logic      i_rst,
	input  logic      i_start, // one-cycle strobe
	input  logic      i_last,  // final multiply step from the counter
	output step_ctl_t o_ctl,
	output logic      o_busy,
	output logic      o_done
);

	mul_state_e state_q, state_d;

	//////////////////////////////////////////////////////////////////////
	// state sequencing
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:  if (i_start) state_d = ST_MUL; // start while busy never reaches here
			ST_MUL:   if (i_last) state_d = ST_NORM;
			ST_NORM:  state_d = ST_ROUND;
			ST_ROUND: state_d = ST_PACK;
			ST_PACK:  state_d = ST_IDLE;
			default:  state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_rclk) begin
		if (i_rst) begin
			state_q <= ST_IDLE;
			o_done  <= 1'b0;
		end else begin
			state_q <= state_d;
			o_done  <= o_ctl.pack; // lands with result regs
		end
	end

	// strobes decoded straight from state
	always_comb begin
		o_ctl          = '0;
		o_ctl.load     = (state_q == ST_IDLE) && i_start;
		o_ctl.mul_step = (state_q == ST_MUL);
		o_ctl.norm     = (state_q == ST_NORM);
		o_ctl.round    = (state_q == ST_ROUND);
		o_ctl.pack     = (state_q == ST_PACK);
	end

	assign o_busy = (state_q != ST_IDLE); // drops as o_done rises

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// a start while busy is dropped, not queued
	a_no_start_busy: assert property (@(posedge i_rclk) disable iff (i_rst)
		o_busy |-> !i_start)
		else $warning("start while busy ignored");

	a_done_pulse: assert property (@(posedge i_rclk) disable iff (i_rst)
		o_done |=> !o_done);

endmodule

/* design/fpu_mul_step_cnt.sv */
`timescale 1ns/10ps
`include "fpu_mul_settings.svh"

module fpu_mul_step_cnt
	import fpu_mul_ctl_pkg::*;
(
	input  logic      i_rclk,
	input  logic      i_rst,
	input  step_ctl_t i_ctl, // load and mul_step only
	output logic      o_last
);

	localparam int CNT_W = $clog2(`FPU_MUL_STEPS);

	logic [CNT_W-1:0] cnt_q; // steps already retired

	// high for the whole twelfth step
	assign o_last = (cnt_q == CNT_W'(`FPU_MUL_STEPS - 1));

	always_ff @(posedge i_rclk) begin
		if (i_rst || i_ctl.load)
			cnt_q <= '0;
		else if (i_ctl.mul_step)
			cnt_q <= o_last ? '0 : cnt_q + 1'b1; // wraps back for next op
	end

	a_cnt_range: assert property (@(posedge i_rclk) disable iff (i_rst)
		cnt_q <= CNT_W'(`FPU_MUL_STEPS - 1));

endmodule

/* design/fpu_mul_frac_dp.sv */
`timescale 1ns/10ps
`include "fpu_mul_settings.svh"

module fpu_mul_frac_dp
	import fpu_mul_fmt_pkg::*;
	import fpu_mul_ctl_pkg::*;
(
	input  logic                   i_rclk,
	input  logic                   i_rst,
	input  step_ctl_t              i_ctl,
	input  fp_word_t               i_op_a,
	input  fp_word_t               i_op_b,
	input  res_sel_e               i_res_sel,   // from exponent side, valid at pack
	output logic                   o_norm_inc,  // product >= 2.0, valid in norm cycle
	output logic                   o_rnd_carry, // round went to 2.0, valid in round cycle
	output logic                   o_rnd_nx,    // discarded bits, valid at pack
	output logic [`FPU_FRAC_W-1:0] o_frac
);

	localparam int SIG_W  = `FPU_FRAC_W + 1; // with hidden one
	localparam int PROD_W = 2 * SIG_W;

	logic [SIG_W-1:0]       mcand_q;  // multiplicand, a side
	logic [SIG_W-1:0]       mplr_q;   // multiplier, b side, shifts right
	logic [PROD_W-1:0]      prod_q;   // partial product, then normalized
	logic [SIG_W+1:0]       pp;       // mcand times two multiplier bits
	logic [SIG_W+1:0]       step_sum;
	logic                   rnd_lsb, rnd_grd, rnd_stk, rnd_up;
	logic [SIG_W:0]         rnd_sum;
	logic [`FPU_FRAC_W-1:0] rnd_frac_q;
	logic                   nx_q;

	// zero and denormal both give a zero significand
	function automatic logic [SIG_W-1:0] sig_of(fp_word_t w);
		return (w.exp != '0) ? {1'b1, w.frac} : '0;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// radix-4 shift-add array
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (mplr_q[1:0])
			2'd0: pp = '0;
			2'd1: pp = {2'b00, mcand_q};
			2'd2: pp = {1'b0, mcand_q, 1'b0};
			default: pp = {2'b00, mcand_q} + {1'b0, mcand_q, 1'b0}; // 3x = 1x + 2x
		endcase
	end

	// add into upper half, fits in 26 bits
	assign step_sum = {2'b00, prod_q[PROD_W-1:SIG_W]} + pp;

	//////////////////////////////////////////////////////////////////////
	// normalize and round
	//////////////////////////////////////////////////////////////////////

	// after norm the leading one sits at bit 46, lsb at 23
	assign o_norm_inc = prod_q[PROD_W-1];

	assign rnd_lsb = prod_q[SIG_W-1];
	assign rnd_grd = prod_q[SIG_W-2];
	assign rnd_stk = |prod_q[SIG_W-3:0];
	assign rnd_up  = rnd_grd && (rnd_stk || rnd_lsb); // ties to even

	assign rnd_sum     = {1'b0, prod_q[PROD_W-2:SIG_W-1]} + rnd_up;
	assign o_rnd_carry = rnd_sum[SIG_W]; // fraction already zero then
	assign o_rnd_nx    = nx_q;

	always_ff @(posedge i_rclk) begin
		if (i_ctl.load) begin
			mcand_q <= sig_of(i_op_a);
			mplr_q  <= sig_of(i_op_b);
			prod_q  <= '0;
		end else if (i_ctl.mul_step) begin
			prod_q <= {step_sum, prod_q[SIG_W-1:2]};
			mplr_q <= mplr_q >> 2;
		end else if (i_ctl.norm && prod_q[PROD_W-1]) begin
			// shifted-out bit folded into sticky
			prod_q <= {1'b0, prod_q[PROD_W-1:2], |prod_q[1:0]};
		end
		if (i_ctl.round) begin
			rnd_frac_q <= rnd_sum[`FPU_FRAC_W-1:0];
			nx_q       <= rnd_grd || rnd_stk;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// fraction pack
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_rst) begin
			o_frac <= '0;
		end else if (i_ctl.pack) begin
			case (i_res_sel)
				RES_NUM:  o_frac <= rnd_frac_q;
				RES_QNAN: o_frac <= {1'b1, {(`FPU_FRAC_W-1){1'b0}}}; // quiet bit only
				default:  o_frac <= '0; // zero and infinity
			endcase
		end
	end

	// a numeric result implies a normalized product
	a_norm_lead: assert property (@(posedge i_rclk) disable iff (i_rst)
		(i_ctl.pack && i_res_sel == RES_NUM) |-> prod_q[PROD_W-2]);

endmodule

/* design/fpu_mul_exp_dp.sv */
`timescale 1ns/10ps
`include "fpu_mul_settings.svh"

module fpu_mul_exp_dp
	import fpu_mul_fmt_pkg::*;
	import fpu_mul_ctl_pkg::*;
(
	input  logic                  i_rclk,
	input  logic                  i_rst,
	input  step_ctl_t             i_ctl,
	input  fp_word_t              i_op_a,
	input  fp_word_t              i_op_b,
	input  logic                  i_norm_inc,
	input  logic                  i_rnd_carry,
	input  logic                  i_rnd_nx,
	output res_sel_e              o_res_sel, // decided here only
	output logic                  o_sign,
	output logic [`FPU_EXP_W-1:0] o_exp,
	output mul_flags_t            o_flags
);

	localparam int EW      = `FPU_EXP_W + 2;          // room for sign and 2x range
	localparam int EXP_MAX = (1 << `FPU_EXP_W) - 1;   // 255 is inf/nan

	op_class_e            cls_a_q, cls_b_q;
	logic                 sign_q;
	logic signed [EW-1:0] exp_q;  // unbiased sum plus bias, may go out of range
	logic                 any_nan, any_inf, any_zero;
	logic                 ovf, unf;
	mul_flags_t           flags_d;

	function automatic op_class_e classify(fp_word_t w);
		if (w.exp == '0)
			return CLS_ZERO; // denormal flushed
		if (w.exp != '1)
			return CLS_NORM;
		return (w.frac != '0) ? CLS_NAN : CLS_INF;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// capture and exponent adjust
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_ctl.load) begin
			cls_a_q <= classify(i_op_a);
			cls_b_q <= classify(i_op_b);
			sign_q  <= i_op_a.sign ^ i_op_b.sign;
			exp_q   <= $signed({2'b00, i_op_a.exp}) + $signed({2'b00, i_op_b.exp})
				- $signed(EW'(`FPU_EXP_BIAS));
		end else if (i_ctl.norm) begin
			exp_q <= exp_q + $signed({{(EW-1){1'b0}}, i_norm_inc});
		end else if (i_ctl.round) begin
			exp_q <= exp_q + $signed({{(EW-1){1'b0}}, i_rnd_carry});
		end
	end

	//////////////////////////////////////////////////////////////////////
	// result select, special operands first
	//////////////////////////////////////////////////////////////////////

	assign any_nan  = (cls_a_q == CLS_NAN) || (cls_b_q == CLS_NAN);
	assign any_inf  = (cls_a_q == CLS_INF) || (cls_b_q == CLS_INF);
	assign any_zero = (cls_a_q == CLS_ZERO) || (cls_b_q == CLS_ZERO);

	always_comb begin
		ovf = 1'b0;
		unf = 1'b0;
		if (any_nan || (any_inf && any_zero))
			o_res_sel = RES_QNAN; // inf times zero too
		else if (any_inf)
			o_res_sel = RES_INF;
		else if (any_zero)
			o_res_sel = RES_ZERO;
		else if (exp_q >= EXP_MAX) begin
			o_res_sel = RES_INF;
			ovf       = 1'b1;
		end else if (exp_q <= 0) begin
			o_res_sel = RES_ZERO; // flush, no denormal out
			unf       = 1'b1;
		end else
			o_res_sel = RES_NUM;
	end

	always_comb begin
		flags_d.invalid   = (o_res_sel == RES_QNAN);
		flags_d.overflow  = ovf;
		flags_d.underflow = unf;
		// round bits only count for a real number
		flags_d.inexact   = ((o_res_sel == RES_NUM) && i_rnd_nx) || ovf || unf;
	end

	always_ff @(posedge i_rclk) begin
		if (i_rst) begin
			o_sign  <= 1'b0;
			o_exp   <= '0;
			o_flags <= '0;
		end else if (i_ctl.pack) begin
			o_sign  <= (o_res_sel == RES_QNAN) ? 1'b0 : sign_q; // canonical nan positive
			o_flags <= flags_d;
			case (o_res_sel)
				RES_NUM:  o_exp <= exp_q[`FPU_EXP_W-1:0];
				RES_ZERO: o_exp <= '0;
				default:  o_exp <= '1; // inf and nan
			endcase
		end
	end

endmodule

/* design/fpu_mul.sv */
`timescale 1ns/10ps

module fpu_mul
	import fpu_mul_fmt_pkg::*;
	import fpu_mul_ctl_pkg::*;
(
	input  logic       i_rclk,
	input  logic       i_rst,
	input  logic       i_start, // one-cycle, ignored while busy
	input  fp_word_t   i_op_a,
	input  fp_word_t   i_op_b,
	output logic       o_busy,
	output logic       o_done,  // fifteen cycles after start
	output fp_word_t   o_result,
	output mul_flags_t o_flags
);

	step_ctl_t                    ctl;
	logic                         last;
	logic                         norm_inc, rnd_carry, rnd_nx;
	res_sel_e                     res_sel;
	logic                         res_sign;
	logic [$bits(o_result.exp)-1:0]  res_exp;
	logic [$bits(o_result.frac)-1:0] res_frac;

	//////////////////////////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////////////////////////

	fpu_mul_ctl u_ctl (
		.i_rclk  (i_rclk),
		.i_rst   (i_rst),
		.i_start (i_start),
		.i_last  (last),
		.o_ctl   (ctl),
		.o_busy  (o_busy),
		.o_done  (o_done)
	);

	fpu_mul_step_cnt u_step_cnt (
		.i_rclk (i_rclk),
		.i_rst  (i_rst),
		.i_ctl  (ctl),
		.o_last (last)
	);

	//////////////////////////////////////////////////////////////////////
	// datapaths
	//////////////////////////////////////////////////////////////////////

	fpu_mul_frac_dp u_frac_dp (
		.i_rclk      (i_rclk),
		.i_rst       (i_rst),
		.i_ctl       (ctl),
		.i_op_a      (i_op_a),
		.i_op_b      (i_op_b),
		.i_res_sel   (res_sel),
		.o_norm_inc  (norm_inc),
		.o_rnd_carry (rnd_carry),
		.o_rnd_nx    (rnd_nx),
		.o_frac      (res_frac)
	);

	fpu_mul_exp_dp u_exp_dp (
		.i_rclk      (i_rclk),
		.i_rst       (i_rst),
		.i_ctl       (ctl),
		.i_op_a      (i_op_a),
		.i_op_b      (i_op_b),
		.i_norm_inc  (norm_inc),
		.i_rnd_carry (rnd_carry),
		.i_rnd_nx    (rnd_nx),
		.o_res_sel   (res_sel),
		.o_sign      (res_sign),
		.o_exp       (res_exp),
		.o_flags     (o_flags)
	);

	assign o_result = {res_sign, res_exp, res_frac}; // all three registered at pack

endmodule

/* bench/tb_fpu_mul.sv */
`timescale 1ns/10ps
`include "fpu_mul_settings.svh"

module tb_fpu_mul;

	localparam int NUM_VEC  = 21;
	localparam int NUM_RAND = 200;
	localparam int TIMEOUT  = 40;                 // cycles allowed per wait
	localparam int LATENCY  = `FPU_MUL_STEPS + 3; // steps, then norm, round, pack

	// one table row, flags are invalid, overflow, underflow, inexact
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [3:0]  flg;
	} vec_t;

	logic        i_rclk;
	logic        i_rst;
	logic        i_start;
	logic [31:0] i_op_a;
	logic [31:0] i_op_b;
	logic        o_busy;
	logic        o_done;
	logic [31:0] o_result;
	logic [3:0]  o_flags;

	vec_t        vectors [NUM_VEC];
	int          val_errs;
	int          tmo_errs;
	int          seed;
	logic [31:0] rnd_a, rnd_b, rnd_ea, rnd_eb; // raw random words
	logic [31:0] op_a, op_b;
	logic [35:0] expect_v;                     // result, then flags

	fpu_mul dut (
		.i_rclk   (i_rclk),
		.i_rst    (i_rst),
		.i_start  (i_start),
		.i_op_a   (i_op_a),
		.i_op_b   (i_op_b),
		.o_busy   (o_busy),
		.o_done   (o_done),
		.o_result (o_result),
		.o_flags  (o_flags)
	);

	initial begin
		i_rclk = 1'b0;
		forever #20 i_rclk = ~i_rclk; // 40 ns period
	end

	//////////////////////////////////////////////////////////////////////
	// reference model, flush-to-zero, nearest even
	//////////////////////////////////////////////////////////////////////

	function automatic logic [35:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
		logic [47:0] p;
		logic [24:0] sig;
		logic        sgn, grd, stk;
		logic        a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
		int          e;
		sgn    = a[31] ^ b[31];
		a_zero = (a[30:23] == 8'h00); // denormals count as zero
		b_zero = (b[30:23] == 8'h00);
		a_inf  = (a[30:23] == 8'hFF) && (a[22:0] == 23'h0);
		b_inf  = (b[30:23] == 8'hFF) && (b[22:0] == 23'h0);
		a_nan  = (a[30:23] == 8'hFF) && (a[22:0] != 23'h0);
		b_nan  = (b[30:23] == 8'hFF) && (b[22:0] != 23'h0);
		if (a_nan || b_nan || (a_inf && b_zero) || (b_inf && a_zero))
			return {32'h7FC00000, 4'b1000};
		if (a_inf || b_inf)
			return {sgn, 8'hFF, 23'h0, 4'b0000};
		if (a_zero || b_zero)
			return {sgn, 31'h0, 4'b0000};
		p = {24'h0, 1'b1, a[22:0]} * {24'h0, 1'b1, b[22:0]}; // 24 x 24 integer product
		e = int'(a[30:23]) + int'(b[30:23]) - 127;
		if (p[47]) begin // product in [2,4)
			e   = e + 1;
			sig = {1'b0, p[47:24]};
			grd = p[23];
			stk = |p[22:0];
		end else begin
			sig = {1'b0, p[46:23]};
			grd = p[22];
			stk = |p[21:0];
		end
		if (grd && (stk || sig[0]))
			sig = sig + 25'd1;
		if (sig[24]) begin // rounded up to 2.0
			e   = e + 1;
			sig = sig >> 1;
		end
		if (e >= 255)
			return {sgn, 8'hFF, 23'h0, 4'b0101};
		if (e <= 0)
			return {sgn, 31'h0, 4'b0011};
		return {sgn, e[7:0], sig[22:0], 3'b000, grd | stk};
	endfunction

	// exponent kept in 1..254
	function automatic logic [31:0] make_normal(input logic [31:0] bits, input logic [31:0] ebits);
		logic [7:0] e;
		e = 8'(ebits % 32'd254) + 8'd1;
		return {bits[31], e, bits[22:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			val_errs++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// one multiply, optional stray start while busy
	//////////////////////////////////////////////////////////////////////

	task automatic run_mul(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] exp_res, input logic [3:0] exp_flg, input bit poke);
		int cycles;
		bit got;
		@(negedge i_rclk);
		i_op_a  = a;
		i_op_b  = b;
		i_start = 1'b1;
		@(negedge i_rclk); // edge 0 took the start
		i_start = 1'b0;
		cycles  = 0;
		got     = 1'b0;
		while (!got && cycles < TIMEOUT) begin
			@(negedge i_rclk);
			cycles++;
			if (o_done) begin
				got = 1'b1;
			end else begin
				check_value("o_busy", o_busy, 1);
				if (poke && cycles == 4) begin
					i_start = 1'b1; // must be dropped
					i_op_a  = ~a;
					i_op_b  = ~b;
				end else if (poke && cycles == 5) begin
					i_start = 1'b0;
				end
			end
		end
		if (!got) begin
			$display("timeout: no o_done within %0d cycles for %h times %h", TIMEOUT, a, b);
			tmo_errs++;
		end else begin
			check_value("o_done latency", cycles, LATENCY);
			check_value("o_busy", o_busy, 0); // falls with done
			check_value("o_result", o_result, exp_res);
			check_value("o_flags", o_flags, exp_flg);
			@(negedge i_rclk);
			check_value("o_done", o_done, 0); // single-cycle pulse
		end
	endtask

	task automatic load_table();
		// operand a, operand b, result, flags
		vectors[0]  = {32'h3FC00000, 32'h40000000, 32'h40400000, 4'h0}; // 1.5 x 2
		vectors[1]  = {32'hC0400000, 32'h40200000, 32'hC0F00000, 4'h0}; // -3 x 2.5
		vectors[2]  = {32'h3F800000, 32'h3F800000, 32'h3F800000, 4'h0};
		vectors[3]  = {32'h7F7FFFFF, 32'h3F800000, 32'h7F7FFFFF, 4'h0}; // largest normal
		vectors[4]  = {32'h00800000, 32'h3F800000, 32'h00800000, 4'h0}; // smallest normal
		vectors[5]  = {32'h3F800001, 32'h3FC00000, 32'h3FC00002, 4'h1}; // tie, odd goes up
		vectors[6]  = {32'h3F800003, 32'h3FC00000, 32'h3FC00004, 4'h1}; // tie, even stays
		vectors[7]  = {32'h3F800001, 32'h3F800001, 32'h3F800002, 4'h1}; // below half
		vectors[8]  = {32'h3FC00001, 32'h3FC00001, 32'h40100002, 4'h1}; // above half, normalized
		vectors[9]  = {32'h3FFFFFFE, 32'h3F800001, 32'h40000000, 4'h1}; // round carry to 2.0
		vectors[10] = {32'h7F800001, 32'h3F800000, 32'h7FC00000, 4'h8}; // signaling nan
		vectors[11] = {32'hFFC00000, 32'hFF800000, 32'h7FC00000, 4'h8};
		vectors[12] = {32'h7F800000, 32'h00000000, 32'h7FC00000, 4'h8}; // inf x 0
		vectors[13] = {32'h7F800000, 32'h00000001, 32'h7FC00000, 4'h8}; // inf x denormal
		vectors[14] = {32'hFF800000, 32'h40000000, 32'hFF800000, 4'h0};
		vectors[15] = {32'h80000000, 32'h40400000, 32'h80000000, 4'h0};
		vectors[16] = {32'h00400000, 32'hC0000000, 32'h80000000, 4'h0}; // denormal flushed
		vectors[17] = {32'h7F000000, 32'h40000000, 32'h7F800000, 4'h5}; // overflow
		vectors[18] = {32'hFF000000, 32'h40000000, 32'hFF800000, 4'h5};
		vectors[19] = {32'h00800000, 32'h3F000000, 32'h00000000, 4'h3}; // underflow
		vectors[20] = {32'h80800000, 32'h3F000000, 32'h80000000, 4'h3};
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		i_rst    = 1'b1;
		i_start  = 1'b0;
		i_op_a   = '0;
		i_op_b   = '0;
		val_errs = 0;
		tmo_errs = 0;
		seed     = 34;
		load_table();
		repeat (8) @(negedge i_rclk);
		i_rst = 1'b0;
		@(negedge i_rclk);
		check_value("o_busy", o_busy, 0);
		check_value("o_done", o_done, 0);
		check_value("o_result", o_result, 0);
		check_value("o_flags", o_flags, 0);

		for (int i = 0; i < NUM_VEC; i++)
			run_mul(vectors[i].a, vectors[i].b, vectors[i].res, vectors[i].flg, 1'b0);

		run_mul(32'h3FC00000, 32'h40000000, 32'h40400000, 4'h0, 1'b1); // start while busy

		for (int n = 0; n < NUM_RAND; n++) begin
			rnd_a    = $random(seed);
			rnd_ea   = $random(seed);
			rnd_b    = $random(seed);
			rnd_eb   = $random(seed);
			op_a     = make_normal(rnd_a, rnd_ea);
			op_b     = make_normal(rnd_b, rnd_eb);
			expect_v = ref_mul(op_a, op_b);
			run_mul(op_a, op_b, expect_v[35:4], expect_v[3:0], 1'b0);
		end

		$display("checks done: %0d value errors, %0d timeouts", val_errs, tmo_errs);
		if (val_errs == 0 && tmo_errs == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* fpu_mul.f */
+incdir+design
design/fpu_mul_fmt_pkg.sv
design/fpu_mul_ctl_pkg.sv
design/fpu_mul_ctl.sv
design/fpu_mul_step_cnt.sv
design/fpu_mul_frac_dp.sv
design/fpu_mul_exp_dp.sv
design/fpu_mul.sv
bench/tb_fpu_mul.sv

/* Makefile */
# Verilator build and run for the iterative FP multiplier

VERILATOR  ?= verilator
TOP        ?= tb_fpu_mul
FLIST      ?= fpu_mul.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= TB FAILED
PASS_MSG   ?= TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no verdict found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
